/* verilog/conv_macros.svh */
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// Pixel and weight share one byte format
`define CONV_PIX_W 8

// One 64-bit row word carries eight pixels
`define CONV_ROW_PIX 8

// Square kernel side
`define CONV_K 3

// One processing lane per pixel column
`define CONV_LANES 8

// Nine 16-bit products need four guard bits
`define CONV_SUM_W 20

`endif

/* verilog/conv_pkg.sv */
`default_nettype none

`include "conv_macros.svh"

package conv_pkg;

	// Single pixel or kernel weight
	typedef logic [`CONV_PIX_W-1:0] pixel_t;

	// Pixel 0 sits in the low byte
	typedef pixel_t [`CONV_ROW_PIX-1:0] row_t;

	// Index 0 is the oldest row, placed in the high bits like {A, B, C}
	typedef row_t [0:`CONV_K-1] window_t;

	// Row-major kernel, weight r*3+c, weight 0 in the low byte
	typedef pixel_t [`CONV_K*`CONV_K-1:0] weight_set_t;

	// Full-precision lane result
	typedef logic [`CONV_SUM_W-1:0] lane_sum_t;

endpackage

`default_nettype wire

/* verilog/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

	// Command encoding of the control FSM
	typedef enum logic [1:0] {
		END   = 2'd0,		// Stop for good
		START = 2'd1,		// Begin or resume compute
		HOLD  = 2'd2		// Pause and rewind weight beats
	} conv_cmd_t;

	typedef enum logic [1:0] {
		WAIT    = 2'd0,		// Idle after reset or HOLD
		COMPUTE = 2'd1,		// Lanes produce valid sums
		FINISH  = 2'd2		// Terminal
	} conv_state_t;

endpackage

`default_nettype wire

/* verilog/shift_chain.sv */
`timescale 1ns/1ps
`default_nettype none

module shift_chain #(
	parameter type T = logic,
	parameter int DEPTH = 2
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic i_shift,
	input wire T i_in,
	output T o_stage [DEPTH]		// Index 0 is the oldest entry
);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				o_stage[i] <= '0;
			end
		end else if (i_shift) begin
			for (int i = 0; i < DEPTH - 1; i++) begin
				o_stage[i] <= o_stage[i + 1];		// Age one position
			end
			o_stage[DEPTH - 1] <= i_in;		// Newest entry
		end
	end

endmodule

`default_nettype wire

/* verilog/conv_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_ctrl (
	input wire logic clk,
	input wire logic rst,
	input wire ctrl_pkg::conv_cmd_t i_cmd,
	output logic o_compute,
	output logic o_finish,
	output logic o_hold
);
	import ctrl_pkg::*;

	conv_state_t state;		// Registered state
	conv_state_t state_nxt;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= WAIT;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;		// Unlisted commands keep the state
		case (state)
			WAIT: begin
				if (i_cmd == START) begin
					state_nxt = COMPUTE;
				end else if (i_cmd == END) begin
					state_nxt = FINISH;
				end
			end
			COMPUTE: begin
				if (i_cmd == HOLD) begin
					state_nxt = WAIT;		// Pause, weights may be reloaded
				end else if (i_cmd == END) begin
					state_nxt = FINISH;
				end
			end
			FINISH: state_nxt = FINISH;		// No way out
			default: state_nxt = WAIT;		// Unused encoding recovers to idle
		endcase
	end

	assign o_compute = (state == COMPUTE);		// Feeds the valid delay line
	assign o_finish = (state == FINISH);
	// HOLD rewinds the weight beat in any state
	assign o_hold = (i_cmd == HOLD);

endmodule

`default_nettype wire

/* verilog/weight_loader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module weight_loader (
	input wire logic clk,
	input wire logic rst,
	input wire logic i_w_valid,
	input wire logic [`CONV_ROW_PIX*`CONV_PIX_W-1:0] i_w_data,
	input wire logic i_hold,
	output conv_pkg::weight_set_t o_weights
);
	import conv_pkg::*;

	localparam int KK = `CONV_K * `CONV_K;

	pixel_t [`CONV_ROW_PIX-1:0] beat;		// Incoming word split into bytes
	logic beat_sel;		// 0 first beat, 1 second beat

	assign beat = i_w_data;

	// Beat position, rewound by HOLD
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			beat_sel <= 1'b0;
		end else if (i_hold) begin
			beat_sel <= 1'b0;
		end else if (i_w_valid) begin
			beat_sel <= ~beat_sel;		// Two beats per kernel
		end
	end

	// Weight registers survive HOLD
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_weights <= '0;
		end else if (i_w_valid) begin
			if (!beat_sel) begin
				for (int i = 0; i < `CONV_ROW_PIX; i++) begin
					o_weights[i] <= beat[i];		// Weights 0 to 7
				end
			end else begin
				o_weights[KK-1] <= beat[0];		// Last weight from byte 0
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/window_select.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module window_select (
	input wire logic clk,
	input wire logic rst,
	input wire conv_pkg::row_t i_rows [`CONV_K+1],		// A oldest .. D newest
	input wire logic i_stride,
	output conv_pkg::window_t o_window
);
	import conv_pkg::*;

	window_t win_nxt;

	// Stride 2 slides one row toward the newest end
	always_comb begin
		for (int r = 0; r < `CONV_K; r++) begin
			if (i_stride) begin
				win_nxt[r] = i_rows[r + 1];		// B, C, D
			end else begin
				win_nxt[r] = i_rows[r];		// A, B, C
			end
		end
	end

	// Shared input register for all lanes
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_window <= '0;
		end else begin
			o_window <= win_nxt;
		end
	end

endmodule

`default_nettype wire

/* verilog/conv_pe.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv_pe #(
	parameter int LANE = 0
) (
	input wire logic clk,
	input wire logic rst,
	input wire conv_pkg::window_t i_window,
	input wire conv_pkg::weight_set_t i_weights,
	output conv_pkg::lane_sum_t o_sum
);
	import conv_pkg::*;

	localparam int KK = `CONV_K * `CONV_K;
	localparam int PROD_W = 2 * `CONV_PIX_W;		// Full product width

	pixel_t [KK-1:0] patch;		// Row-major like the weights
	logic [PROD_W-1:0] prod [KK];		// Stage 1 registers
	lane_sum_t sum_nxt;

	// Columns LANE..LANE+2 wrap past the row end
	always_comb begin
		for (int r = 0; r < `CONV_K; r++) begin
			for (int c = 0; c < `CONV_K; c++) begin
				patch[r*`CONV_K + c] = i_window[r][(LANE + c) % `CONV_ROW_PIX];
			end
		end
	end

	// Stage 1, nine parallel 8x8 multipliers
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int k = 0; k < KK; k++) begin
				prod[k] <= '0;
			end
		end else begin
			for (int k = 0; k < KK; k++) begin
				prod[k] <= PROD_W'(patch[k]) * PROD_W'(i_weights[k]);
			end
		end
	end

	// Adder tree left to synthesis
	always_comb begin
		sum_nxt = '0;
		for (int k = 0; k < KK; k++) begin
			sum_nxt = sum_nxt + lane_sum_t'(prod[k]);		// Zero extend, no overflow
		end
	end

	// Stage 2, registered lane sum
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_sum <= '0;
		end else begin
			o_sum <= sum_nxt;
		end
	end

endmodule

`default_nettype wire

/* verilog/conv3_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv3_top (
	input wire logic clk,
	input wire logic rst,
	input wire ctrl_pkg::conv_cmd_t i_cmd,
	input wire conv_pkg::row_t i_row,
	input wire logic i_row_valid,
	input wire logic i_lpad,
	input wire logic i_stride,
	input wire logic [`CONV_ROW_PIX*`CONV_PIX_W-1:0] i_w_data,
	input wire logic i_w_valid,
	output wire conv_pkg::lane_sum_t [`CONV_LANES-1:0] o_sum,		// Lane 0 in low bits
	output wire logic o_valid,
	output wire logic o_finish
);
	import conv_pkg::*;

	row_t row_in;		// Pixel row or padding zeros
	logic row_shift;
	row_t rows [`CONV_K+1];		// A, B, C, D
	logic compute;
	logic hold;
	logic valid_pipe [3];		// Follows compute through the datapath
	weight_set_t weights;
	window_t window;

	// Left padding pushes a zero row without input data
	assign row_in = i_row_valid ? i_row : '0;
	assign row_shift = i_row_valid | i_lpad;

	shift_chain #(
		.T(row_t),
		.DEPTH(`CONV_K+1)
	) i_row_chain (
		.clk(clk),
		.rst(rst),
		.i_shift(row_shift),
		.i_in(row_in),
		.o_stage(rows)
	);

	conv_ctrl i_conv_ctrl (
		.clk(clk),
		.rst(rst),
		.i_cmd(i_cmd),
		.o_compute(compute),
		.o_finish(o_finish),
		.o_hold(hold)
	);

	// Matches window, product and sum registers
	shift_chain #(
		.T(logic),
		.DEPTH(3)
	) i_valid_chain (
		.clk(clk),
		.rst(rst),
		.i_shift(1'b1),
		.i_in(compute),
		.o_stage(valid_pipe)
	);

	assign o_valid = valid_pipe[0];		// Oldest stage

	weight_loader i_weight_loader (
		.clk(clk),
		.rst(rst),
		.i_w_valid(i_w_valid),
		.i_w_data(i_w_data),
		.i_hold(hold),
		.o_weights(weights)
	);

	window_select i_window_select (
		.clk(clk),
		.rst(rst),
		.i_rows(rows),
		.i_stride(i_stride),
		.o_window(window)
	);

	// One lane per output column
	for (genvar lane = 0; lane < `CONV_LANES; lane++) begin : g_lane
		conv_pe #(
			.LANE(lane)
		) i_conv_pe (
			.clk(clk),
			.rst(rst),
			.i_window(window),
			.i_weights(weights),
			.o_sum(o_sum[lane])
		);
	end

endmodule

`default_nettype wire

/* verif/conv3_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module conv3_chk (
	input wire logic clk,
	input wire logic rst,
	input wire logic i_compute,		// Control state is COMPUTE
	input wire logic i_valid,
	input wire logic i_finish
);

	// FINISH has no exit
	finish_sticky: assert property (@(posedge clk) disable iff (!rst)
		i_finish |=> i_finish)
		else $error("o_finish dropped after being set");

	// Window, product and sum registers sit between state and o_valid
	valid_needs_compute: assert property (@(posedge clk) disable iff (!rst)
		!$past(i_compute, 3) |-> !i_valid)
		else $error("o_valid high without compute three cycles earlier");

	// Pipeline drained three cycles into FINISH
	valid_off_after_finish: assert property (@(posedge clk) disable iff (!rst)
		i_finish && $past(i_finish, 3) |-> !i_valid)
		else $error("o_valid high three cycles after o_finish");

endmodule

`default_nettype wire

/* verif/tb_conv3.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module tb_conv3;
	import conv_pkg::*;
	import ctrl_pkg::*;

	localparam int N_ROWS = 40;		// Rows per streaming test
	localparam int TEST_CYCLES = 4 * N_ROWS + 40;		// Upper bound of all tests together
	localparam int MAX_CYCLES = 10 * TEST_CYCLES;		// Generous margin
	localparam conv_cmd_t CMD_NOP = conv_cmd_t'(2'd3);		// Unused code keeps the state

	logic clk;
	logic rst;
	conv_cmd_t cmd;
	row_t row;
	logic row_valid;
	logic lpad;
	logic stride;
	logic [63:0] w_data;
	logic w_valid;
	lane_sum_t [`CONV_LANES-1:0] sum;
	logic valid;
	logic finish;

	row_t m_rows [4];		// Reference row chain, index 0 oldest
	row_t rows_old [4];		// Chain before the current edge
	pixel_t m_w [9];		// Reference kernel, row-major
	logic m_beat;		// Reference beat position
	conv_state_t m_state;
	logic [3:0] cmp_hist;		// Bit 3 is compute three edges back
	lane_sum_t pred_hist [3][`CONV_LANES];		// Index 2 is the sum due now
	int cycles = 0;

	conv3_top i_conv3_top (
		.clk(clk),
		.rst(rst),
		.i_cmd(cmd),
		.i_row(row),
		.i_row_valid(row_valid),
		.i_lpad(lpad),
		.i_stride(stride),
		.i_w_data(w_data),
		.i_w_valid(w_valid),
		.o_sum(sum),
		.o_valid(valid),
		.o_finish(finish)
	);

	bind conv3_top conv3_chk i_conv3_chk (
		.clk(clk),
		.rst(rst),
		.i_compute(compute),
		.i_valid(o_valid),
		.i_finish(o_finish)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;		// 8 ns period

	// Lane result straight from the convolution rule with column wrap
	function automatic lane_sum_t expect_lane(input row_t rows [4], input logic str,
		input pixel_t w [9], input int lane);
		lane_sum_t acc;
		row_t r_sel;
		logic [2:0] col;
		acc = '0;
		for (int r = 0; r < 3; r++) begin
			r_sel = str ? rows[r + 1] : rows[r];		// Stride 2 uses B, C, D
			for (int c = 0; c < 3; c++) begin
				col = 3'((lane + c) % 8);
				acc = acc + lane_sum_t'(r_sel[col]) * lane_sum_t'(w[r*3 + c]);
			end
		end
		return acc;
	endfunction

	task automatic fail_check(input string msg);
		$display("FAIL %0t: %s", $time, msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "Stopped at first error");
	endtask

	// Reference model follows the inputs as the DUT samples them
	always @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < 4; i++) begin
				m_rows[i] = '0;
			end
			for (int i = 0; i < 9; i++) begin
				m_w[i] = '0;
			end
			m_beat = 1'b0;
			m_state = WAIT;
			cmp_hist = '0;
			for (int d = 0; d < 3; d++) begin
				for (int l = 0; l < `CONV_LANES; l++) begin
					pred_hist[d][l] = '0;
				end
			end
		end else begin
			rows_old = m_rows;		// Window register sees the chain before this edge
			if (row_valid || lpad) begin
				for (int i = 0; i < 3; i++) begin
					m_rows[i] = m_rows[i + 1];
				end
				m_rows[3] = row_valid ? row : '0;		// Padding pushes zeros
			end
			if (w_valid) begin
				if (!m_beat) begin
					for (int i = 0; i < 8; i++) begin
						m_w[i] = w_data[8*i +: 8];
					end
				end else begin
					m_w[8] = w_data[7:0];		// Second beat only feeds weight 8
				end
			end
			if (cmd == HOLD) begin
				m_beat = 1'b0;
			end else if (w_valid) begin
				m_beat = ~m_beat;
			end
			case (m_state)
				WAIT: begin
					if (cmd == START) begin
						m_state = COMPUTE;
					end else if (cmd == END) begin
						m_state = FINISH;
					end
				end
				COMPUTE: begin
					if (cmd == HOLD) begin
						m_state = WAIT;
					end else if (cmd == END) begin
						m_state = FINISH;
					end
				end
				default: begin
					m_state = m_state;		// FINISH is terminal
				end
			endcase
			cmp_hist = {cmp_hist[2:0], m_state == COMPUTE};
			pred_hist[2] = pred_hist[1];
			pred_hist[1] = pred_hist[0];
			// Products use the weights after this edge
			for (int l = 0; l < `CONV_LANES; l++) begin
				pred_hist[0][l] = expect_lane(rows_old, stride, m_w, l);
			end
		end
	end

	// Registered outputs are settled at the falling edge
	always @(negedge clk) begin
		if (rst) begin
			assert (valid === cmp_hist[3])
				else fail_check($sformatf("o_valid is %b, expected %b", valid, cmp_hist[3]));
			assert (finish === (m_state == FINISH))
				else fail_check($sformatf("o_finish is %b in state %s", finish, m_state.name()));
			if (valid) begin
				for (int l = 0; l < `CONV_LANES; l++) begin
					assert (sum[l] === pred_hist[2][l])
						else fail_check($sformatf("lane %0d sum 0x%05h, expected 0x%05h",
							l, sum[l], pred_hist[2][l]));
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
			$display("*** TEST FAILED ***");
			$fatal(1, "Timeout");
		end
	end

	task automatic send_cmd(input conv_cmd_t c);
		cmd = c;
		@(negedge clk);
		cmd = CMD_NOP;		// One-cycle command pulse
	endtask

	task automatic load_beat(input logic [63:0] data);
		w_data = data;
		w_valid = 1'b1;
		@(negedge clk);
		w_valid = 1'b0;
	endtask

	task automatic load_kernel();
		load_beat({$urandom, $urandom});		// Weights 0 to 7
		load_beat({$urandom, $urandom});		// Weight 8 from byte 0
	endtask

	task automatic stream_rows(input int n);
		for (int i = 0; i < n; i++) begin
			row = {$urandom, $urandom};
			row_valid = 1'b1;
			@(negedge clk);
		end
		row_valid = 1'b0;
	endtask

	// Random mix of padding, data rows and idle cycles
	task automatic pad_mix(input int n);
		int pick;
		for (int i = 0; i < n; i++) begin
			pick = int'($urandom % 3);
			row = {$urandom, $urandom};
			row_valid = (pick == 1);
			lpad = (pick == 0);
			@(negedge clk);
		end
		row_valid = 1'b0;
		lpad = 1'b0;
	endtask

	initial begin
		void'($urandom(34654));
		rst = 1'b0;
		cmd = CMD_NOP;
		row = '0;
		row_valid = 1'b0;
		lpad = 1'b0;
		stride = 1'b0;
		w_data = '0;
		w_valid = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
		@(negedge clk);

		load_kernel();		// Stride 1 stream
		send_cmd(START);
		stream_rows(N_ROWS);
		repeat (4) @(negedge clk);

		stride = 1'b1;		// Stride 2 stream
		stream_rows(N_ROWS);
		repeat (4) @(negedge clk);

		stride = 1'b0;		// Zero rows from left padding
		pad_mix(30);
		repeat (4) @(negedge clk);

		load_beat({$urandom, $urandom});		// Partial kernel, then HOLD
		send_cmd(HOLD);
		repeat (6) @(negedge clk);
		load_kernel();
		send_cmd(START);
		stream_rows(20);
		repeat (4) @(negedge clk);

		send_cmd(END);
		stream_rows(8);
		send_cmd(START);		// Ignored once finished
		repeat (8) @(negedge clk);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+verilog
verilog/conv_pkg.sv
verilog/ctrl_pkg.sv
verilog/shift_chain.sv
verilog/conv_ctrl.sv
verilog/weight_loader.sv
verilog/window_select.sv
verilog/conv_pe.sv
verilog/conv3_top.sv
verif/conv3_chk.sv
verif/tb_conv3.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the conv3 testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f verilog.f \
	--top-module tb_conv3 \
	-o sim_tb_conv3

# A $fatal or failed assertion gives a nonzero exit status
./obj_dir/sim_tb_conv3
